// File: source/fifo_settings.svh
/*
 * FIFO buffer sizing
 * word width and storage depth used by the package and by every RTL block
 * the depth does not have to be a power of two, but it must be at least 2
 */

`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// width of one data word in bits
`define FIFO_WORD_WIDTH 16

// number of words the FIFO holds before it stops accepting input
// 5 is not a power of two, so the address wrap logic is always in use
`define FIFO_DEPTH 5

`endif

// File: source/fifo_pkg.sv
/*
 * FIFO buffer types
 * vector types for data words, RAM addresses and the stored-item count,
 * all sized from the settings header
 */

`include "fifo_settings.svh"

package fifo_pkg;

    // one data item as it passes through the buffer
    typedef logic [`FIFO_WORD_WIDTH-1:0] fifo_word_t;

    // RAM address, wide enough to reach entry DEPTH-1
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_addr_t;

    // item count from 0 up to and including DEPTH
    // the count has to reach DEPTH itself, so it needs one bit more than an address
    typedef logic [$clog2(`FIFO_DEPTH):0] fifo_count_t;

endpackage

// File: source/fifo_storage_ram.sv
/*
 * FIFO storage RAM
 * simple dual-port memory with one synchronous write port and one
 * registered read port, DEPTH words deep
 */

`include "fifo_settings.svh"

module fifo_storage_ram (
    input  logic                 clock,
    input  logic                 write_enable,
    input  fifo_pkg::fifo_addr_t write_addr,
    input  fifo_pkg::fifo_word_t write_data,
    input  logic                 read_enable,
    input  fifo_pkg::fifo_addr_t read_addr,
    output fifo_pkg::fifo_word_t read_data
);
    import fifo_pkg::*;

    // the storage array itself, small enough for LUT RAM or block RAM
    fifo_word_t storage [`FIFO_DEPTH];

    // write port, one word per enabled cycle
    always_ff @(posedge clock) begin
        if (write_enable) begin
            storage[write_addr] <= write_data;
        end
    end

    // registered read port
    // the data only changes on an enabled read, so the output word holds
    // for as long as the consumer applies back-pressure
    // the control never reads and writes one address in the same cycle,
    // so no write-forwarding path is needed here
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_data <= storage[read_addr];
        end
    end

endmodule

// File: source/fifo_address_counters.sv
/*
 * FIFO address counters
 * write and read addresses for the storage RAM; each one steps by one
 * when advanced and wraps from DEPTH-1 back to zero, which allows any depth
 */

`include "fifo_settings.svh"

module fifo_address_counters (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 advance_write,
    input  logic                 advance_read,
    output fifo_pkg::fifo_addr_t write_addr,
    output fifo_pkg::fifo_addr_t read_addr
);
    import fifo_pkg::*;

    // last valid RAM entry, after which both addresses return to zero
    localparam fifo_addr_t ADDR_LAST = fifo_addr_t'(`FIFO_DEPTH - 1);

    // next address in the ring
    // a plain binary increment would run past DEPTH-1 when the depth is
    // not a power of two, so the last entry is caught explicitly
    function automatic fifo_addr_t step_addr(input fifo_addr_t addr);
        if (addr == ADDR_LAST) begin
            return '0;
        end
        return addr + 1'b1;
    endfunction

    // the two addresses never pass each other
    // equal addresses mean either empty or full, and the item count in the
    // flow control is what tells those two cases apart
    always_ff @(posedge clock) begin
        if (!rst_n || clear) begin
            write_addr <= '0;
            read_addr  <= '0;
        end else begin
            // write address moves after each word stored in the RAM
            if (advance_write) begin
                write_addr <= step_addr(write_addr);
            end
            // read address moves after each word taken out of the RAM
            if (advance_read) begin
                read_addr <= step_addr(read_addr);
            end
        end
    end

endmodule

// File: source/fifo_flow_control.sv
/*
 * FIFO flow control
 * keeps the item count, decodes empty, busy and full from it, turns the
 * input and output handshakes into load, unload and flow, and drives the
 * RAM and address controls
 * also holds the output-valid register that follows the registered RAM read
 */

`include "fifo_settings.svh"

module fifo_flow_control (
    input  logic clock,
    input  logic rst_n,
    input  logic clear,
    input  logic input_valid,
    output logic input_ready,
    output logic output_valid,
    input  logic output_ready,
    output logic write_enable,
    output logic read_enable,
    output logic advance_write,
    output logic advance_read
);
    import fifo_pkg::*;

    localparam fifo_count_t COUNT_FULL = fifo_count_t'(`FIFO_DEPTH);

    // number of words held by the FIFO, the only state of the control
    // it also covers the word waiting in the output register, so the whole
    // buffer never holds more than DEPTH words
    fifo_count_t item_count;

    logic empty;
    logic busy;
    logic full;
    logic storage_empty;
    logic update_output;
    logic insert;
    logic remove;
    logic load;
    logic unload;
    logic flow;

    // state decode from the count
    // storage_empty is true when every counted word already sits in the
    // output register, so there is nothing left in the RAM to read
    always_comb begin
        empty         = (item_count == '0);
        full          = (item_count == COUNT_FULL);
        busy          = !empty && !full;
        storage_empty = (item_count == fifo_count_t'(output_valid));
    end

    // input side only stops the producer when the FIFO is full
    always_comb begin
        input_ready = !full;
        insert      = input_valid && input_ready;
    end

    // output side
    // the output register may take a new word when it is empty or when its
    // current word leaves this cycle, so it also pre-loads while the
    // consumer is not ready
    always_comb begin
        update_output = !output_valid || output_ready;
        read_enable   = !storage_empty && update_output;
        remove        = output_valid && output_ready;
    end

    // transformations of the count
    // a remove is impossible while empty and an insert while full, so
    // both at once can only happen in the busy range
    always_comb begin
        load   = !full && insert && !remove;
        unload = !empty && !insert && remove;
        flow   = busy && insert && remove;
    end

    // every accepted word goes straight into the RAM
    assign write_enable  = load || flow;
    assign advance_write = write_enable;

    // every RAM read moves a word from the RAM into the output register,
    // so the read address steps on each read, pre-load reads included
    assign advance_read = read_enable;

    always_ff @(posedge clock) begin
        if (!rst_n || clear) begin
            item_count <= '0;
        end else if (load) begin
            item_count <= item_count + 1'b1;
        end else if (unload) begin
            item_count <= item_count - 1'b1;
        end
    end

    // output_valid follows read_enable with the RAM read latency
    // it is frozen while a valid word waits for the consumer, and drops
    // when the register updates with no RAM word to read
    always_ff @(posedge clock) begin
        if (!rst_n || clear) begin
            output_valid <= 1'b0;
        end else if (update_output) begin
            output_valid <= read_enable;
        end
    end

endmodule

// File: source/fifo_buffer_top.sv
/*
 * pipelined ready/valid FIFO buffer
 * decouples an input stream from an output stream with no combinational
 * path between the two sides; holds up to DEPTH words, any depth allowed
 * clear returns the buffer to empty, just as reset does
 */

module fifo_buffer_top (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 input_valid,
    output logic                 input_ready,
    input  fifo_pkg::fifo_word_t input_data,
    output logic                 output_valid,
    input  logic                 output_ready,
    output fifo_pkg::fifo_word_t output_data
);
    import fifo_pkg::*;

    logic       write_enable;
    logic       read_enable;
    logic       advance_write;
    logic       advance_read;
    fifo_addr_t write_addr;
    fifo_addr_t read_addr;

    // handshakes, item count and output-valid register
    fifo_flow_control fifo_flow_control_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .clear         (clear),
        .input_valid   (input_valid),
        .input_ready   (input_ready),
        .output_valid  (output_valid),
        .output_ready  (output_ready),
        .write_enable  (write_enable),
        .read_enable   (read_enable),
        .advance_write (advance_write),
        .advance_read  (advance_read)
    );

    // wrapping RAM addresses
    fifo_address_counters fifo_address_counters_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .clear         (clear),
        .advance_write (advance_write),
        .advance_read  (advance_read),
        .write_addr    (write_addr),
        .read_addr     (read_addr)
    );

    // the registered read port drives the output data directly
    fifo_storage_ram fifo_storage_ram_i (
        .clock        (clock),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (input_data),
        .read_enable  (read_enable),
        .read_addr    (read_addr),
        .read_data    (output_data)
    );

endmodule

// File: tb/fifo_buffer_asserts.sv
/*
 * FIFO buffer assertions
 * concurrent checks bound into the top level: the output word holds while
 * the consumer stalls, and reset or clear leave the handshakes idle
 */

module fifo_buffer_asserts (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 clear,
    input logic                 input_ready,
    input logic                 output_valid,
    input logic                 output_ready,
    input fifo_pkg::fifo_word_t output_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions, read by the testbench at the end of the run
    int failure_count = 0;

    // a stalled output word stays valid and unchanged until it is taken
    // a clear in the stall cycle empties the buffer, so it is left out
    output_held_a: assert property (
        @(posedge clock) disable iff (!rst_n)
        (output_valid && !output_ready && !clear) |=> (output_valid && $stable(output_data))
    ) else begin
        failure_count++;
        $error("output word changed while the consumer stalled");
    end

    // the empty buffer accepts input right away
    ready_after_reset_a: assert property (
        @(posedge clock) (!rst_n || clear) |=> input_ready
    ) else begin
        failure_count++;
        $error("input_ready low in the cycle after reset or clear");
    end

    // and has nothing to offer
    valid_after_reset_a: assert property (
        @(posedge clock) (!rst_n || clear) |=> !output_valid
    ) else begin
        failure_count++;
        $error("output_valid high in the cycle after reset or clear");
    end

endmodule

// File: tb/fifo_buffer_tb.sv
/*
 * FIFO buffer testbench
 * drives the buffer through a table of stimulus phases with LFSR-based
 * valid, ready and data, and checks every output word against a queue model
 * directed checks cover the reset state and the single-word latency
 */

`include "fifo_settings.svh"

module fifo_buffer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fifo_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h259c_549b;
    localparam int DONT_CARE = -1;
    localparam int NUM_PHASES = 11;

    // one stimulus phase, probabilities are in sixteenths
    typedef struct packed {
        int   cycles;
        int   valid_prob;
        int   ready_prob;
        logic clear_flag;
        int   expect_ready;
    } phase_t;

    // cycles, valid, ready, clear, expected input_ready at the end of the phase
    localparam phase_t PHASE_TABLE [NUM_PHASES] = '{
        '{12, 16, 0, 1'b0, 0},
        '{20, 0, 16, 1'b0, 1},
        '{300, 10, 9, 1'b0, DONT_CARE},
        '{20, 0, 16, 1'b0, 1},
        '{3, 16, 0, 1'b0, 1},
        '{1, 0, 0, 1'b1, 1},
        '{40, 16, 16, 1'b0, 1},
        '{300, 6, 14, 1'b0, DONT_CARE},
        '{300, 14, 5, 1'b0, DONT_CARE},
        '{2, 0, 0, 1'b1, 1},
        '{200, 9, 9, 1'b0, DONT_CARE}
    };

    logic       clock;
    logic       rst_n;
    logic       clear;
    logic       input_valid;
    logic       input_ready;
    fifo_word_t input_data;
    logic       output_valid;
    logic       output_ready;
    fifo_word_t output_data;

    // words accepted by the DUT and not yet delivered, oldest first
    fifo_word_t  scoreboard [$];
    logic [31:0] lfsr_state;
    // a word offered but not yet accepted has to stay on the input
    logic        holding;
    int          error_count;

    fifo_buffer_top fifo_buffer_top_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .clear        (clear),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    bind fifo_buffer_top fifo_buffer_asserts fifo_buffer_asserts_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .clear        (clear),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // taps 32, 22, 2 and 1 give a maximal-length sequence
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_fatal(input string reason);
        $display("STATUS: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            error_count++;
            report_fatal("value mismatch");
        end
    endtask

    // one clock cycle, entered and left on a falling edge
    // inputs are driven first, the transfers of the coming rising edge are
    // applied to the model, and the model is compared after that edge
    task automatic run_cycle(input int valid_prob, input int ready_prob, input logic clear_now,
                             output logic in_fire, output logic out_fire);
        logic [31:0] bits;
        fifo_word_t  expected;
        if (clear_now) begin
            clear        = 1'b1;
            input_valid  = 1'b0;
            output_ready = 1'b0;
            holding      = 1'b0;
            // everything held by the buffer is dropped at this edge
            scoreboard.delete();
        end else begin
            clear = 1'b0;
            if (!holding) begin
                draw_bits(4, bits);
                input_valid = (int'(bits) < valid_prob);
                draw_bits(`FIFO_WORD_WIDTH, bits);
                input_data = bits[`FIFO_WORD_WIDTH-1:0];
            end
            draw_bits(4, bits);
            output_ready = (int'(bits) < ready_prob);
        end
        in_fire  = input_valid && input_ready;
        out_fire = output_valid && output_ready;
        if (out_fire) begin
            expected = scoreboard.pop_front();
            check_equal(32'(output_data), 32'(expected), "output word against scoreboard");
        end
        if (in_fire) begin
            scoreboard.push_back(input_data);
        end
        holding = input_valid && !in_fire;
        @(negedge clock);
        // input_ready is low exactly when DEPTH words are held
        check_equal(32'(input_ready), 32'(scoreboard.size() < `FIFO_DEPTH),
                    "input_ready against words held");
        if (scoreboard.size() == 0) begin
            check_equal(32'(output_valid), 32'd0, "output_valid with no words held");
        end
    endtask

    // keep the consumer ready until every accepted word came out
    task automatic drain_fifo(input int max_cycles);
        int   waited;
        logic in_fire;
        logic out_fire;
        waited = 0;
        while ((scoreboard.size() != 0 || holding) && waited < max_cycles) begin
            run_cycle(0, 16, 1'b0, in_fire, out_fire);
            waited++;
        end
        if (scoreboard.size() != 0 || holding) begin
            $display("timeout: the FIFO still held %0d words after %0d drain cycles",
                     scoreboard.size(), max_cycles);
            report_fatal("drain timeout");
        end
    endtask

    initial begin
        logic       in_fire;
        logic       out_fire;
        fifo_word_t first_word;
        int         assert_failures;
        rst_n        = 1'b0;
        clear        = 1'b0;
        input_valid  = 1'b0;
        input_data   = '0;
        output_ready = 1'b0;
        lfsr_state   = LFSR_SEED;
        holding      = 1'b0;
        error_count  = 0;

        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check_equal(32'(input_ready), 32'd1, "input_ready after reset");
        check_equal(32'(output_valid), 32'd0, "output_valid after reset");

        // single word through the empty buffer, read one edge after the write
        run_cycle(16, 16, 1'b0, in_fire, out_fire);
        check_equal(32'(in_fire), 32'd1, "first word accepted into empty FIFO");
        first_word = scoreboard[0];
        check_equal(32'(output_valid), 32'd0, "output_valid one edge after acceptance");
        run_cycle(0, 16, 1'b0, in_fire, out_fire);
        check_equal(32'(output_valid), 32'd1, "output_valid two edges after acceptance");
        check_equal(32'(output_data), 32'(first_word), "first word on output_data");
        run_cycle(0, 16, 1'b0, in_fire, out_fire);
        check_equal(32'(out_fire), 32'd1, "first word taken by the consumer");

        for (int p = 0; p < NUM_PHASES; p++) begin
            for (int c = 0; c < PHASE_TABLE[p].cycles; c++) begin
                run_cycle(PHASE_TABLE[p].valid_prob, PHASE_TABLE[p].ready_prob,
                          PHASE_TABLE[p].clear_flag, in_fire, out_fire);
                // with both sides always active, one word moves per cycle once filled
                if (PHASE_TABLE[p].valid_prob == 16 && PHASE_TABLE[p].ready_prob == 16 &&
                    c >= `FIFO_DEPTH) begin
                    check_equal(32'(in_fire), 32'd1, "input transfer in steady flow");
                    check_equal(32'(out_fire), 32'd1, "output transfer in steady flow");
                end
            end
            if (PHASE_TABLE[p].expect_ready != DONT_CARE) begin
                check_equal(32'(input_ready), 32'(PHASE_TABLE[p].expect_ready),
                            "input_ready at end of phase");
            end
            if (PHASE_TABLE[p].expect_ready == 0) begin
                check_equal(32'(scoreboard.size()), 32'(`FIFO_DEPTH), "words held when full");
            end
            if (PHASE_TABLE[p].clear_flag) begin
                check_equal(32'(output_valid), 32'd0, "output_valid after clear");
            end
        end

        drain_fifo(4 * `FIFO_DEPTH + 8);

        assert_failures = fifo_buffer_top_i.fifo_buffer_asserts_i.failure_count;
        if (assert_failures != 0) begin
            $display("%0d assertion failures were reported during the run", assert_failures);
            error_count += assert_failures;
        end
        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_fatal("errors were recorded during the run");
        end
    end

endmodule

// File: files.f
+incdir+source
source/fifo_pkg.sv
source/fifo_storage_ram.sv
source/fifo_address_counters.sv
source/fifo_flow_control.sv
source/fifo_buffer_top.sv
tb/fifo_buffer_asserts.sv
tb/fifo_buffer_tb.sv

// File: Makefile
# Verilator build and run for the FIFO buffer testbench
# every variable below can be overridden on the make command line

VERILATOR  ?= verilator
TOP        ?= fifo_buffer_tb
FILE_LIST  ?= files.f
BUILD_DIR  ?= obj_dir
LOG_FILE   ?= sim.log
PASS_TEXT  ?= STATUS: PASS
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
SIM_ARGS   ?= +verilator+error+limit+100

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only if the log holds the pass line
run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG_FILE)
	@grep -qx "$(PASS_TEXT)" $(LOG_FILE) || (echo "simulation failed, see $(LOG_FILE)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
